/* idecodeBranch.sv */
`timescale 1ns/1ps
`default_nettype none

module idecodeBranch (
	input  idecodePkg::unitClass_t unitClass,
	input  idecodePkg::instr_t     instr,
	output idecodePkg::brFlags_t   br
);
	import idecodePkg::*;

	always_comb
	begin
		br = '0;
		if (unitClass.isB)
		begin
			case (instr.opcode4)
				opBcc, opBBc, opBEQI:
					br.br = 1'b1;
				opBRcc:
					br.brcc = 1'b1;
				opJMP:
					br.jmp = 1'b1;
				opCALL:
					br.call = 1'b1;
				opCHK, opCHKI:
				begin
					br.br = 1'b1;
					br.chk = 1'b1;
					br.chki = instr.opcode4 == opCHKI;
					br.canEx = 1'b1;
				end
				opJAL:
					br.jal = 1'b1;
				opRET:
					br.ret = 1'b1;
				opBRK:
				begin
					br.brk = 1'b1;
					// Hardware interrupts arrive as BRK with the top bit set
					br.irq = instr.funct5[4];
					br.canEx = 1'b1;
				end
				opBMISC:
				begin
					br.sei = instr.funct5 == fnSEI;
					br.rti = instr.funct5 == fnRTI;
					br.waitOp = instr.funct5 == fnWAIT;
				end
				default:
					br = '0;
			endcase
		end
	end

endmodule

`default_nettype wire

/* idecodeConst.sv */
`timescale 1ns/1ps
`default_nettype none

module idecodeConst (
	input  idecodePkg::unitClass_t unitClass,
	input  idecodePkg::instr_t     instr,
	output logic [63:0]            constVal,
	output logic                   imm
);
	import idecodePkg::*;

	logic [39:0] raw;
	logic        isChki;
	logic        isStore;

	assign raw = instr;
	assign isChki = unitClass.isB && instr.opcode4 == opCHKI;
	assign isStore = unitClass.isM && instr.memMod[1];

	// Bit 39 is the sign in every layout
	always_comb
	begin
		if (isStore)
			constVal = {{44{raw[39]}}, raw[39:35], raw[30:22], raw[5:0]};
		else if (unitClass.isM)
			constVal = {{44{raw[39]}}, raw[39:35], raw[30:16]};
		else if (isChki)
			constVal = {{42{raw[39]}}, raw[39:33], raw[30:22], raw[5:0]};
		else
			constVal = {{42{raw[39]}}, raw[39:33], raw[30:16]};
	end

	// Constant-present flag
	always_comb
	begin
		imm = 1'b0;
		if (unitClass.isB)
			imm = isChki || instr.opcode4 == opJAL;
		else if (unitClass.isI)
			imm = !isR3Form(instr);
		else if (unitClass.isM)
			imm = instr.opcode4 <= memLastSized;
	end

endmodule

`default_nettype wire

/* idecodeCtrl.sv */
`timescale 1ns/1ps
`default_nettype none

module idecodeCtrl (
	input  logic                   clk,
	input  logic                   rstN,
	input  logic                   instrValid,
	input  idecodePkg::unit_t      unit,
	input  idecodePkg::instr_t     instr,
	output idecodePkg::unitClass_t unitClass,
	input  logic [63:0]            constVal,
	input  logic                   imm,
	input  idecodePkg::regTarget_t rd,
	input  idecodePkg::regTarget_t rd2,
	input  logic [5:0]             rs1,
	input  logic [5:0]             rs2,
	input  logic [5:0]             rs3,
	input  idecodePkg::brFlags_t   br,
	input  idecodePkg::memFlags_t  mem,
	output logic                   decValid,
	output idecodePkg::decodeBus_t dec
);
	import idecodePkg::*;

	logic       isR3;
	logic       intCanEx;
	logic       isSyncOp;
	logic       hasTarget;
	decodeBus_t nextDec;

	// ========================================
	// Unit classification
	// ========================================
	assign unitClass.isB = unit == unitB;
	assign unitClass.isI = unit == unitI;
	assign unitClass.isM = unit == unitM;

	assign isR3 = unitClass.isI && isR3Form(instr);

	// Multiply and divide can trap on overflow or divide by zero
	always_comb
	begin
		intCanEx = 1'b0;
		if (isR3)
			intCanEx = instr.funct5 == fnMUL || instr.funct5 == fnDIV
				|| instr.funct5 == fnMOD;
		else if (unitClass.isI && instr.opExt == 2'b00)
			intCanEx = instr.opcode4 == opMULI || instr.opcode4 == opDIVI
				|| instr.opcode4 == opMODI;
	end

	assign isSyncOp = unitClass.isB && instr.opcode4 == opBMISC && instr.funct5 == fnSYNC;
	assign hasTarget = rd.num != 6'd0 || rd2.num != 6'd0;

	always_comb
	begin
		nextDec = '0;
		nextDec.constVal = constVal;
		nextDec.imm = imm;
		nextDec.rs1 = rs1;
		nextDec.rs2 = rs2;
		nextDec.rs3 = rs3;
		nextDec.rd = rd;
		nextDec.rd2 = rd2;
		nextDec.sz = isR3 ? instr.szFld : wordSize;
		nextDec.br = br;
		nextDec.mem = mem;
		// Targets the predictor cannot know ahead of time
		nextDec.bt = br.jal || br.ret || br.brk || br.rti;
		nextDec.sync = isSyncOp || br.rti || br.brk;
		nextDec.canEx = intCanEx || br.canEx || mem.canEx;
		nextDec.rfw = hasTarget && (unitClass.isI
			|| br.call || br.jal || br.ret || br.sei
			|| mem.load || mem.push || mem.pop);
		nextDec.alu = unitClass.isI;
		nextDec.fc = unitClass.isB;
		nextDec.unit = unit;
	end

	// ========================================
	// Output register
	// ========================================
	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			decValid <= 1'b0;
			dec <= '0;
		end
		else
		begin
			decValid <= instrValid;
			if (instrValid)
				dec <= nextDec;
		end
	end

endmodule

`default_nettype wire

/* idecodeMem.sv */
`timescale 1ns/1ps
`default_nettype none

module idecodeMem (
	input  idecodePkg::unitClass_t unitClass,
	input  idecodePkg::instr_t     instr,
	output idecodePkg::memFlags_t  mem
);
	import idecodePkg::*;

	logic       isAccess;
	logic       isStore;
	logic [2:0] accessSz;

	// Opcode4 8 to 15 are reserved and do neither
	assign isAccess = !instr.opcode4[3];
	assign isStore = instr.memMod[1];

	// ========================================
	// Access size
	// ========================================
	always_comb
	begin
		case (instr.opcode4)
			4'd0:
				accessSz = byt;
			4'd1:
				accessSz = wyde;
			4'd2:
				accessSz = tetra;
			4'd3:
				accessSz = penta;
			4'd4:
				accessSz = octa;
			4'd5:
				accessSz = deci;
			memNdx:
				accessSz = instr.funct5[2:0] > deci ? deci : instr.funct5[2:0];
			default:
				accessSz = deci;
		endcase
	end

	always_comb
	begin
		mem = '0;
		if (unitClass.isM)
		begin
			mem.mem = 1'b1;
			mem.load = isAccess && !isStore;
			mem.store = isAccess && isStore;
			mem.push = instr.opcode4 == memStack && isStore;
			mem.pop = instr.opcode4 == memStack && !isStore;
			mem.ndx = instr.opcode4 == memNdx;
			mem.mem2 = instr.opcode4 == memStack;
			mem.memSz = accessSz;
			// Any access may fault on translation
			mem.canEx = 1'b1;
		end
	end

endmodule

`default_nettype wire

/* idecodePkg.sv */
`default_nettype none

package idecodePkg;

	// ========================================
	// Unit codes
	// ========================================
	typedef logic [2:0] unit_t;

	localparam unit_t unitB = 3'd1;
	localparam unit_t unitI = 3'd2;
	localparam unit_t unitM = 3'd4;

	// Instruction overlay, msb first
	typedef struct packed {
		logic [4:0] funct5;
		logic [1:0] memMod;	// upper bit selects store
		logic [1:0] opExt;
		logic [2:0] szFld;
		logic [5:0] rs3;
		logic [5:0] rs2;
		logic [5:0] rs1;
		logic [3:0] opcode4;
		logic [5:0] rd;
	} instr_t;

	// ========================================
	// Opcode and function values
	// ========================================
	localparam logic [3:0] opBcc = 4'd0;
	localparam logic [3:0] opBBc = 4'd1;
	localparam logic [3:0] opBRcc = 4'd2;
	localparam logic [3:0] opJMP = 4'd3;
	localparam logic [3:0] opBEQI = 4'd4;
	localparam logic [3:0] opCALL = 4'd5;
	localparam logic [3:0] opCHK = 4'd6;
	localparam logic [3:0] opCHKI = 4'd7;
	localparam logic [3:0] opJAL = 4'd8;
	localparam logic [3:0] opRET = 4'd9;
	localparam logic [3:0] opBRK = 4'd10;
	localparam logic [3:0] opBMISC = 4'd11;

	// BMISC sub-functions in funct5
	localparam logic [4:0] fnSEI = 5'd0;
	localparam logic [4:0] fnRTI = 5'd1;
	localparam logic [4:0] fnSYNC = 5'd2;
	localparam logic [4:0] fnWAIT = 5'd3;

	// Integer unit
	localparam logic [3:0] opR3 = 4'd2;
	localparam logic [3:0] opMULI = 4'd12;
	localparam logic [3:0] opDIVI = 4'd13;
	localparam logic [3:0] opMODI = 4'd14;
	localparam logic [4:0] fnMUL = 5'd8;
	localparam logic [4:0] fnDIV = 5'd9;
	localparam logic [4:0] fnMOD = 5'd10;

	// Memory unit, opcode4 0 to 5 are sized accesses
	localparam logic [3:0] memLastSized = 4'd5;
	localparam logic [3:0] memNdx = 4'd6;
	localparam logic [3:0] memStack = 4'd7;

	// Access sizes
	localparam logic [2:0] byt = 3'd0;
	localparam logic [2:0] wyde = 3'd1;
	localparam logic [2:0] tetra = 3'd2;
	localparam logic [2:0] penta = 3'd3;
	localparam logic [2:0] octa = 3'd4;
	localparam logic [2:0] deci = 3'd5;

	localparam logic [6:0] callLinkReg = 7'd61;
	localparam logic [2:0] wordSize = 3'd3;

	// ========================================
	// Decode structures
	// ========================================
	typedef struct packed {
		logic       fileSel;
		logic [5:0] num;
	} regTarget_t;

	typedef struct packed {
		logic isB;
		logic isI;
		logic isM;
	} unitClass_t;

	typedef struct packed {
		logic br;
		logic brcc;
		logic jmp;
		logic call;
		logic ret;
		logic jal;
		logic brk;
		logic irq;
		logic rti;
		logic sei;
		logic waitOp;
		logic chk;
		logic chki;
		logic canEx;
	} brFlags_t;

	typedef struct packed {
		logic       mem;
		logic       load;
		logic       store;
		logic       push;
		logic       pop;
		logic       ndx;
		logic       mem2;
		logic [2:0] memSz;
		logic       canEx;
	} memFlags_t;

	typedef struct packed {
		logic [63:0] constVal;
		logic        imm;
		logic [5:0]  rs1;
		logic [5:0]  rs2;
		logic [5:0]  rs3;
		regTarget_t  rd;
		regTarget_t  rd2;
		logic [2:0]  sz;
		brFlags_t    br;
		memFlags_t   mem;
		logic        bt;
		logic        sync;
		logic        canEx;
		logic        rfw;
		logic        alu;
		logic        fc;
		unit_t       unit;
	} decodeBus_t;

	// Three-register integer form
	function automatic logic isR3Form(input instr_t ins);
		return ins.opExt == 2'b00 && ins.opcode4 == opR3;
	endfunction

endpackage

`default_nettype wire

/* idecodeRegs.sv */
`timescale 1ns/1ps
`default_nettype none

module idecodeRegs (
	input  idecodePkg::unitClass_t unitClass,
	input  idecodePkg::instr_t     instr,
	output idecodePkg::regTarget_t rd,
	output idecodePkg::regTarget_t rd2,
	output logic [5:0]             rs1,
	output logic [5:0]             rs2,
	output logic [5:0]             rs3
);
	import idecodePkg::*;

	logic isStackOp;

	assign isStackOp = unitClass.isM && instr.opcode4 == memStack;

	// Primary target
	always_comb
	begin
		rd = '0;
		if (unitClass.isB)
		begin
			case (instr.opcode4)
				opCALL:
					rd = callLinkReg;
				opJAL, opRET:
					rd = {1'b0, instr.rd};
				opBMISC:
					if (instr.funct5 == fnSEI)
						rd = {1'b0, instr.rd};
				default:
					rd = '0;
			endcase
		end
		else if (unitClass.isI)
			rd = {1'b0, instr.rd};
		// Loads including pop; push leaves Rd clear
		else if (unitClass.isM && !instr.memMod[1] && !instr.opcode4[3])
			rd = {1'b0, instr.rd};
	end

	// Push and pop update the stack pointer held in Rs1
	assign rd2 = isStackOp ? {1'b0, instr.rs1} : '0;

	assign rs1 = instr.rs1;
	assign rs2 = instr.rs2;
	assign rs3 = instr.rs3;

endmodule

`default_nettype wire

/* idecoder.f */
+incdir+.
idecodePkg.sv
idecodeConst.sv
idecodeRegs.sv
idecodeBranch.sv
idecodeMem.sv
idecodeCtrl.sv
idecoder.sv
idecoderTb.sv

/* idecoder.sv */
`timescale 1ns/1ps
`default_nettype none

module idecoder (
	input  logic                   clk,
	input  logic                   rstN,
	input  logic                   instrValid,
	input  idecodePkg::unit_t      unit,
	input  idecodePkg::instr_t     instr,
	output logic                   decValid,
	output idecodePkg::decodeBus_t dec
);
	import idecodePkg::*;

	unitClass_t  unitClass;
	logic [63:0] constVal;
	logic        imm;
	regTarget_t  rd;
	regTarget_t  rd2;
	logic [5:0]  rs1;
	logic [5:0]  rs2;
	logic [5:0]  rs3;
	brFlags_t    brFlags;
	memFlags_t   memFlags;

	// Datapath decode, all combinational
	idecodeConst constInst (.unitClass, .instr, .constVal, .imm);

	idecodeRegs regsInst (.unitClass, .instr, .rd, .rd2, .rs1, .rs2, .rs3);

	idecodeBranch branchInst (.unitClass, .instr, .br(brFlags));

	idecodeMem memInst (.unitClass, .instr, .mem(memFlags));

	// Unit classification and the registered bundle
	idecodeCtrl ctrlInst (
		.clk,
		.rstN,
		.instrValid,
		.unit,
		.instr,
		.unitClass,
		.constVal,
		.imm,
		.rd,
		.rd2,
		.rs1,
		.rs2,
		.rs3,
		.br(brFlags),
		.mem(memFlags),
		.decValid,
		.dec
	);

endmodule

`default_nettype wire

/* idecoderTbModel.svh */
`ifndef IDECODER_TB_MODEL_SVH
`define IDECODER_TB_MODEL_SVH

// Expected decode bundle, built from raw bit positions and opcode numbers
function automatic idecodePkg::decodeBus_t expectDecode(
	input idecodePkg::unit_t  unit,
	input idecodePkg::instr_t instr
);
	idecodePkg::decodeBus_t d;
	logic [39:0] raw;
	logic [3:0]  op;
	logic [4:0]  f5;
	logic        isB;
	logic        isI;
	logic        isM;
	logic        r3;

	d = '0;
	raw = instr;
	op = raw[9:6];
	f5 = raw[39:35];
	isB = unit == 3'd1;
	isI = unit == 3'd2;
	isM = unit == 3'd4;
	r3 = isI && raw[32:31] == 2'b00 && op == 4'd2;

	// Constant layouts
	if (isM && raw[34])
		d.constVal = {{44{raw[39]}}, raw[39:35], raw[30:22], raw[5:0]};
	else if (isM)
		d.constVal = {{44{raw[39]}}, raw[39:35], raw[30:16]};
	else if (isB && op == 4'd7)
		d.constVal = {{42{raw[39]}}, raw[39:33], raw[30:22], raw[5:0]};
	else
		d.constVal = {{42{raw[39]}}, raw[39:33], raw[30:16]};
	d.rs1 = raw[15:10];
	d.rs2 = raw[21:16];
	d.rs3 = raw[27:22];
	d.sz = r3 ? raw[30:28] : 3'd3;
	d.alu = isI;
	d.fc = isB;
	d.unit = unit;

	if (isB)
	begin
		d.br.br = op inside {4'd0, 4'd1, 4'd4, 4'd6, 4'd7};
		d.br.brcc = op == 4'd2;
		d.br.jmp = op == 4'd3;
		d.br.call = op == 4'd5;
		d.br.jal = op == 4'd8;
		d.br.ret = op == 4'd9;
		d.br.brk = op == 4'd10;
		d.br.irq = op == 4'd10 && raw[39];
		d.br.sei = op == 4'd11 && f5 == 5'd0;
		d.br.rti = op == 4'd11 && f5 == 5'd1;
		d.br.waitOp = op == 4'd11 && f5 == 5'd3;
		d.br.chk = op inside {4'd6, 4'd7};
		d.br.chki = op == 4'd7;
		d.br.canEx = op inside {4'd6, 4'd7, 4'd10};
		d.imm = op inside {4'd7, 4'd8};
		if (d.br.call)
			d.rd = 7'd61;
		else if (d.br.jal || d.br.ret || d.br.sei)
			d.rd = {1'b0, raw[5:0]};
		d.bt = d.br.jal || d.br.ret || d.br.brk || d.br.rti;
		d.sync = (op == 4'd11 && f5 == 5'd2) || d.br.rti || d.br.brk;
		d.canEx = d.br.canEx;
		d.rfw = d.br.call || d.br.jal || d.br.ret || d.br.sei;
	end
	else if (isI)
	begin
		d.imm = !r3;
		d.rd = {1'b0, raw[5:0]};
		d.canEx = (r3 && f5 inside {5'd8, 5'd9, 5'd10})
			|| (raw[32:31] == 2'b00 && op inside {4'd12, 4'd13, 4'd14});
		d.rfw = 1'b1;
	end
	else if (isM)
	begin
		d.mem.mem = 1'b1;
		d.mem.canEx = 1'b1;
		d.mem.load = op < 4'd8 && !raw[34];
		d.mem.store = op < 4'd8 && raw[34];
		d.mem.push = op == 4'd7 && raw[34];
		d.mem.pop = op == 4'd7 && !raw[34];
		d.mem.ndx = op == 4'd6;
		d.mem.mem2 = op == 4'd7;
		if (op < 4'd6)
			d.mem.memSz = op[2:0];
		else if (op == 4'd6 && f5[2:0] < 3'd6)
			d.mem.memSz = f5[2:0];
		else
			d.mem.memSz = 3'd5;
		d.imm = op < 4'd6;
		if (d.mem.load)
			d.rd = {1'b0, raw[5:0]};
		if (d.mem.mem2)
			d.rd2 = {1'b0, raw[15:10]};
		d.canEx = 1'b1;
		d.rfw = d.mem.load || d.mem.push || d.mem.pop;
	end

	if (d.rd.num == 6'd0 && d.rd2.num == 6'd0)
		d.rfw = 1'b0;
	return d;
endfunction

`endif

/* idecoderTb.sv */
`timescale 1ns/1ps
`default_nettype none

module idecoderTb;
	import idecodePkg::*;

	`include "idecoderTbModel.svh"

	logic       clk = 1'b0;
	logic       rstN;
	logic       instrValid;
	unit_t      unit;
	instr_t     instr;
	logic       decValid;
	decodeBus_t dec;

	integer     seed = 32'h9df9d1c7;
	integer     errorCount = 0;
	integer     checkCount = 0;
	integer     testCount = 0;
	integer     testStartErrors = 0;

	// Expected output state lags the inputs by one cycle
	logic       started = 1'b0;
	logic       pendValid = 1'b0;
	decodeBus_t holdExp = '0;

	idecoder idecoder_inst (
		.clk,
		.rstN,
		.instrValid,
		.unit,
		.instr,
		.decValid,
		.dec
	);

	always #4 clk = ~clk;

	// ========================================
	// Reference tracking and comparison
	// ========================================
	always @(posedge clk)
	begin
		started <= 1'b1;
		if (!rstN)
		begin
			pendValid <= 1'b0;
			holdExp <= '0;
		end
		else
		begin
			pendValid <= instrValid;
			if (instrValid)
				holdExp <= expectDecode(unit, instr);
		end
	end

	task automatic checkField(input string name, input logic [63:0] expVal,
		input logic [63:0] actVal);
		checkCount++;
		assert (actVal === expVal)
		else
		begin
			errorCount++;
			$display("error at %0d ns: %s expected %0h actual %0h", $time, name, expVal, actVal);
		end
	endtask

	// Outputs are stable at the falling edge
	always @(negedge clk)
	begin
		if (started)
		begin
			checkField("decValid", pendValid, decValid);
			checkField("dec.constVal", holdExp.constVal, dec.constVal);
			checkField("dec.imm", holdExp.imm, dec.imm);
			checkField("dec.rs1", holdExp.rs1, dec.rs1);
			checkField("dec.rs2", holdExp.rs2, dec.rs2);
			checkField("dec.rs3", holdExp.rs3, dec.rs3);
			checkField("dec.rd", holdExp.rd, dec.rd);
			checkField("dec.rd2", holdExp.rd2, dec.rd2);
			checkField("dec.sz", holdExp.sz, dec.sz);
			checkField("dec.br", holdExp.br, dec.br);
			checkField("dec.mem", holdExp.mem, dec.mem);
			checkField("dec.bt", holdExp.bt, dec.bt);
			checkField("dec.sync", holdExp.sync, dec.sync);
			checkField("dec.canEx", holdExp.canEx, dec.canEx);
			checkField("dec.rfw", holdExp.rfw, dec.rfw);
			checkField("dec.alu", holdExp.alu, dec.alu);
			checkField("dec.fc", holdExp.fc, dec.fc);
			checkField("dec.unit", holdExp.unit, dec.unit);
		end
	end

	// ========================================
	// Stimulus helpers
	// ========================================
	function automatic instr_t randomInstr();
		logic [31:0] hi;
		logic [31:0] lo;
		hi = $random(seed);
		lo = $random(seed);
		return {hi[7:0], lo};
	endfunction

	task automatic issueInstr(input unit_t u, input instr_t i);
		@(posedge clk);
		#1;
		instrValid = 1'b1;
		unit = u;
		instr = i;
	endtask

	// Inputs wander while idle so the hold behavior is exercised
	task automatic idleCycle();
		logic [31:0] rnd;
		@(posedge clk);
		#1;
		instrValid = 1'b0;
		rnd = $random(seed);
		unit = rnd[2:0];
		instr = randomInstr();
	endtask

	task automatic waitForValid();
		integer n;
		logic   seen;
		seen = 1'b0;
		for (n = 0; n < 4 && !seen; n++)
		begin
			@(negedge clk);
			seen = decValid;
		end
		if (!seen)
		begin
			errorCount++;
			$display("decValid never rose after an instruction strobe");
		end
	endtask

	task automatic drainOutputs();
		integer n;
		logic   quiet;
		idleCycle();
		quiet = 1'b0;
		for (n = 0; n < 5 && !quiet; n++)
		begin
			@(negedge clk);
			quiet = !decValid;
		end
		if (!quiet)
		begin
			errorCount++;
			$display("decValid stayed high after the strobes stopped");
		end
	endtask

	task automatic finishTest(input string name);
		drainOutputs();
		testCount++;
		$display("test %s finished with %0d errors", name, errorCount - testStartErrors);
		testStartErrors = errorCount;
	endtask

	// ========================================
	// Test sequence
	// ========================================
	initial
	begin
		instr_t      i;
		integer      k;
		integer      st;
		logic [31:0] rnd;

		rstN = 1'b0;
		instrValid = 1'b0;
		unit = '0;
		instr = '0;
		repeat (5) @(posedge clk);
		#1;
		rstN = 1'b1;

		// Reset values, single strobe, gap, back to back
		repeat (3) idleCycle();
		issueInstr(unitI, randomInstr());
		idleCycle();
		waitForValid();
		idleCycle();
		issueInstr(unitB, randomInstr());
		issueInstr(unitM, randomInstr());
		finishTest("reset");

		// Every branch opcode, then BMISC functions
		for (k = 0; k < 16; k++)
		begin
			i = randomInstr();
			i.opcode4 = k[3:0];
			issueInstr(unitB, i);
		end
		for (k = 0; k < 8; k++)
		begin
			i = randomInstr();
			i.opcode4 = opBMISC;
			i.funct5 = k[4:0];
			issueInstr(unitB, i);
		end
		for (k = 0; k < 2; k++)
		begin
			i = randomInstr();
			i.opcode4 = opBRK;
			i.funct5[4] = k[0];
			issueInstr(unitB, i);
			i.opcode4 = opCALL;
			issueInstr(unitB, i);
			i.opcode4 = opJAL;
			i.rd = 6'd0;
			issueInstr(unitB, i);
		end
		finishTest("branch");

		// Sized, indexed, stack and reserved memory forms
		for (st = 0; st < 2; st++)
		begin
			for (k = 0; k < 16; k++)
			begin
				i = randomInstr();
				i.opcode4 = k[3:0];
				i.memMod[1] = st[0];
				issueInstr(unitM, i);
			end
			for (k = 0; k < 8; k++)
			begin
				i = randomInstr();
				i.opcode4 = memNdx;
				i.memMod[1] = st[0];
				i.funct5[2:0] = k[2:0];
				issueInstr(unitM, i);
			end
			i = randomInstr();
			i.opcode4 = memStack;
			i.memMod[1] = st[0];
			i.rs1 = 6'd0;
			issueInstr(unitM, i);
		end
		finishTest("memory");

		// R3 functions, immediate forms and a zero target
		for (k = 0; k < 16; k++)
		begin
			i = randomInstr();
			i.opcode4 = opR3;
			i.opExt = 2'b00;
			i.funct5 = k[4:0];
			issueInstr(unitI, i);
		end
		for (k = 12; k < 16; k++)
		begin
			i = randomInstr();
			i.opcode4 = k[3:0];
			i.opExt = 2'b00;
			issueInstr(unitI, i);
			i.opExt = 2'b01;
			issueInstr(unitI, i);
		end
		i = randomInstr();
		i.opcode4 = opR3;
		i.opExt = 2'b00;
		i.funct5 = fnDIV;
		i.rd = 6'd0;
		issueInstr(unitI, i);
		finishTest("integer");

		// Mostly back to back with the odd gap over all unit codes
		for (k = 0; k < 300; k++)
		begin
			rnd = $random(seed);
			if (rnd[2:0] == 3'd0)
				idleCycle();
			else
			begin
				rnd = $random(seed);
				issueInstr(rnd[2:0], randomInstr());
			end
		end
		finishTest("random");

		$display("tests %0d, checks %0d, errors %0d", testCount, checkCount, errorCount);
		if (errorCount == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

`default_nettype wire
